//--- verilog/tile_macros.svh
// ********************
// Tile-wide sizes, address regions and boot ROM contents
// MEM_WORDS, ROM_WORDS and MP_RX_DEPTH must be powers of two
// ********************
`ifndef TILE_MACROS_SVH
`define TILE_MACROS_SVH

`define ADR_W        32                         // Bus address width
`define DAT_W        32                         // Bus data width
`define SEL_W        4                          // Byte selects per word
`define FLIT_TYPE_W  2                          // Flit type field
`define FLIT_W       (`FLIT_TYPE_W + `DAT_W)    // Type on top of payload

`define MEM_WORDS    256                        // Local SRAM depth, address wraps
`define MEM_AW       $clog2(`MEM_WORDS)
`define ROM_WORDS    8                          // Boot ROM depth, address wraps
`define ROM_AW       $clog2(`ROM_WORDS)
`define MP_RX_DEPTH  4                          // Receive queue depth
`define MP_RX_AW     $clog2(`MP_RX_DEPTH)

`define NA_REGION    4'hE                       // Address bits 31:28
`define ROM_REGION   4'hF

// Boot stub: set up stack pointer, jump to start of local SRAM
`define BOOTROM_WORD_0 32'h18000000             // l.movhi r0,0
`define BOOTROM_WORD_1 32'h18200000             // l.movhi r1,0
`define BOOTROM_WORD_2 32'hA8210FFC             // l.ori r1,r1,0x0ffc
`define BOOTROM_WORD_3 32'h18600000             // l.movhi r3,0
`define BOOTROM_WORD_4 32'hA8630100             // l.ori r3,r3,0x100
`define BOOTROM_WORD_5 32'h44001800             // l.jr r3
`define BOOTROM_WORD_6 32'h15000000             // l.nop, delay slot
`define BOOTROM_WORD_7 32'h15000000             // l.nop

`endif

//--- verilog/tile_bus_pkg.sv
// ********************
// Types of the tile bus side
// Widths come from tile_macros.svh
// ********************
`default_nettype none

`include "tile_macros.svh"

package tile_bus_pkg;

   typedef logic [`ADR_W-1:0] wb_adr_t;         // Byte address
   typedef logic [`DAT_W-1:0] wb_dat_t;         // Data word
   typedef logic [`SEL_W-1:0] wb_sel_t;         // One bit per byte lane

   // Bus controller states
   typedef enum logic [1:0] {
      IDLE,                                     // Waiting for cyc and stb
      ACCESS,                                   // Slave strobed, waiting for ack
      RESP                                      // One-cycle ack or err
   } bus_state_t;

endpackage

`default_nettype wire

//--- verilog/tile_noc_pkg.sv
// ********************
// Types of the NoC side, single virtual channel
// ********************
`default_nettype none

`include "tile_macros.svh"

package tile_noc_pkg;

   typedef logic [`DAT_W-1:0]       flit_data_t; // Flit payload
   typedef logic [`FLIT_TYPE_W-1:0] flit_type_t; // 00 payload, 01 header, 10 last, 11 single
   typedef logic [`FLIT_W-1:0]      flit_t;      // {type, payload}

   // Queue fill level, must also hold the full count
   typedef logic [`MP_RX_AW:0] mp_level_t;

endpackage

`default_nettype wire

//--- verilog/wb_bus_ctrl.sv
// ********************
// Tile bus controller, single master, no retry
// Dropping cyc or stb before ack/err is not supported
// Unmapped regions 8 to D answer with err and zero data
// ********************
`timescale 1ns/1ns
`default_nettype none

`include "tile_macros.svh"

module wb_bus_ctrl import tile_bus_pkg::*; (
   input  logic    clk,
   input  logic    rst_i,
   input  wb_adr_t wb_adr_i,
   input  logic    wb_cyc_i,
   input  logic    wb_stb_i,
   input  logic    mem_ack_i,
   input  wb_dat_t mem_dat_i,
   input  logic    na_ack_i,
   input  wb_dat_t na_dat_i,
   input  logic    rom_ack_i,
   input  wb_dat_t rom_dat_i,
   output logic    mem_stb_o,
   output logic    na_stb_o,
   output logic    rom_stb_o,
   output wb_dat_t wb_dat_o,
   output logic    wb_ack_o,
   output logic    wb_err_o
);

   bus_state_t state_q;
   logic [2:0] slv_hit;                         // Decoded {rom, na, mem}
   logic [2:0] slv_q;                           // Registered hit, zero means unmapped
   logic       slv_ack;
   wb_dat_t    slv_dat;
   wb_dat_t    dat_q;

   // Region decode, SRAM owns the whole lower half
   always_comb begin
      slv_hit = 3'b000;
      if (!wb_adr_i[`ADR_W-1])
         slv_hit = 3'b001;
      else if (wb_adr_i[`ADR_W-1 -: 4] == `NA_REGION)
         slv_hit = 3'b010;
      else if (wb_adr_i[`ADR_W-1 -: 4] == `ROM_REGION)
         slv_hit = 3'b100;
   end

   assign mem_stb_o = (state_q == ACCESS) & slv_q[0]; // Level strobe until slave ack
   assign na_stb_o  = (state_q == ACCESS) & slv_q[1];
   assign rom_stb_o = (state_q == ACCESS) & slv_q[2];

   assign slv_ack = |(slv_q & {rom_ack_i, na_ack_i, mem_ack_i});

   always_comb begin
      case (slv_q)
         3'b010:  slv_dat = na_dat_i;
         3'b100:  slv_dat = rom_dat_i;
         default: slv_dat = mem_dat_i;
      endcase
   end

   always_ff @(posedge clk) begin
      if (rst_i) begin
         state_q <= IDLE;
         slv_q   <= 3'b000;
      end else begin
         case (state_q)
            IDLE: begin
               if (wb_cyc_i && wb_stb_i) begin
                  slv_q   <= slv_hit;
                  state_q <= (slv_hit == 3'b000) ? RESP : ACCESS; // Unmapped skips ACCESS
               end
            end
            ACCESS: begin
               if (slv_ack)
                  state_q <= RESP;
            end
            default: state_q <= IDLE;           // RESP lasts one cycle
         endcase
      end
   end

   // Read data, cleared while idle so an error returns zero
   always_ff @(posedge clk) begin
      if (state_q == IDLE)
         dat_q <= '0;
      else if (state_q == ACCESS && slv_ack)
         dat_q <= slv_dat;
   end

   assign wb_dat_o = dat_q;
   assign wb_ack_o = (state_q == RESP) & (slv_q != 3'b000);
   assign wb_err_o = (state_q == RESP) & (slv_q == 3'b000);

endmodule

`default_nettype wire

//--- verilog/wb_sram_sp.sv
// ********************
// Single-port word SRAM, byte-select writes
// Address wraps modulo MEM_WORDS, contents undefined after power-up
// Strobe must drop after each ack
// ********************
`timescale 1ns/1ns
`default_nettype none

`include "tile_macros.svh"

module wb_sram_sp import tile_bus_pkg::*; (
   input  logic    clk,
   input  wb_adr_t wb_adr_i,
   input  wb_dat_t wb_dat_i,
   input  wb_sel_t wb_sel_i,
   input  logic    wb_we_i,
   input  logic    stb_i,
   output logic    ack_o,
   output wb_dat_t dat_o
);

   wb_dat_t             mem [`MEM_WORDS];
   logic [`MEM_AW-1:0]  idx;
   logic                req;

   assign idx = wb_adr_i[`MEM_AW+1:2];          // Word index, upper bits ignored
   assign req = stb_i & ~ack_o;                 // First cycle of an access

   // Ack follows strobe by one cycle, settles low on first idle clock
   always_ff @(posedge clk) begin
      ack_o <= req;
   end

   always_ff @(posedge clk) begin
      if (req && wb_we_i) begin
         for (int b = 0; b < `SEL_W; b++) begin
            if (wb_sel_i[b])
               mem[idx][8*b +: 8] <= wb_dat_i[8*b +: 8]; // Only selected lanes
         end
      end
   end

   // Read port, old word on a write
   always_ff @(posedge clk) begin
      if (req)
         dat_o <= mem[idx];
   end

endmodule

`default_nettype wire

//--- verilog/bootrom.sv
// ********************
// Boot ROM, contents from BOOTROM_WORD macros
// Writes are acked and dropped
// ********************
`timescale 1ns/1ns
`default_nettype none

`include "tile_macros.svh"

module bootrom import tile_bus_pkg::*; (
   input  logic    clk,
   input  logic    rst_i,
   input  wb_adr_t wb_adr_i,
   input  logic    stb_i,
   output logic    ack_o,
   output wb_dat_t dat_o
);

   logic [`ROM_AW-1:0] idx;

   assign idx = wb_adr_i[`ROM_AW+1:2];          // Wraps modulo ROM_WORDS

   always_ff @(posedge clk) begin
      if (rst_i)
         ack_o <= 1'b0;
      else
         ack_o <= stb_i & ~ack_o;               // One pulse per strobe
   end

   always_ff @(posedge clk) begin
      case (idx)
         3'd0:    dat_o <= `BOOTROM_WORD_0;
         3'd1:    dat_o <= `BOOTROM_WORD_1;
         3'd2:    dat_o <= `BOOTROM_WORD_2;
         3'd3:    dat_o <= `BOOTROM_WORD_3;
         3'd4:    dat_o <= `BOOTROM_WORD_4;
         3'd5:    dat_o <= `BOOTROM_WORD_5;
         3'd6:    dat_o <= `BOOTROM_WORD_6;
         default: dat_o <= `BOOTROM_WORD_7;
      endcase
   end

endmodule

`default_nettype wire

//--- verilog/mp_fifo_count.sv
// ********************
// Pointers and level of the receive queue
// Caller must not push when full or pop when empty
// ********************
`timescale 1ns/1ns
`default_nettype none

`include "tile_macros.svh"

module mp_fifo_count import tile_noc_pkg::*; (
   input  logic                 clk,
   input  logic                 rst_i,
   input  logic                 push_i,
   input  logic                 pop_i,
   output logic [`MP_RX_AW-1:0] wr_ptr_o,
   output logic [`MP_RX_AW-1:0] rd_ptr_o,
   output mp_level_t            level_o,
   output logic                 empty_o,
   output logic                 full_o
);

   mp_level_t level_nxt;

   always_comb begin
      level_nxt = level_o;                      // Push with pop keeps the level
      if (push_i && !pop_i)
         level_nxt = level_o + 1'b1;
      else if (pop_i && !push_i)
         level_nxt = level_o - 1'b1;
   end

   always_ff @(posedge clk) begin
      if (rst_i) begin
         wr_ptr_o <= '0;
         rd_ptr_o <= '0;
         level_o  <= '0;
         empty_o  <= 1'b1;
         full_o   <= 1'b0;
      end else begin
         wr_ptr_o <= wr_ptr_o + push_i;         // Power-of-two depth, wraps by itself
         rd_ptr_o <= rd_ptr_o + pop_i;
         level_o  <= level_nxt;
         empty_o  <= (level_nxt == '0);
         full_o   <= (level_nxt == mp_level_t'(`MP_RX_DEPTH));
      end
   end

endmodule

`default_nettype wire

//--- verilog/mp_simple_na.sv
// ********************
// Message-passing adapter, one virtual channel
// Write offset n sends a flit of type n, held off while send reg is full
// Read 0 pops payload, 1 gives level, 2 peeks type, 3 reads zero
// ********************
`timescale 1ns/1ns
`default_nettype none

`include "tile_macros.svh"

module mp_simple_na import tile_bus_pkg::*, tile_noc_pkg::*; (
   input  logic    clk,
   input  logic    rst_i,
   input  wb_adr_t wb_adr_i,
   input  wb_dat_t wb_dat_i,
   input  logic    wb_we_i,
   input  logic    stb_i,
   input  flit_t   noc_in_flit_i,
   input  logic    noc_in_valid_i,
   input  logic    noc_out_ready_i,
   output logic    ack_o,
   output wb_dat_t dat_o,
   output logic    noc_in_ready_o,
   output flit_t   noc_out_flit_o,
   output logic    noc_out_valid_o,
   output logic    irq_o
);

   logic [1:0]           offset;
   logic                 req;
   logic                 send_free;
   logic                 do_send;
   logic                 push;
   logic                 pop;
   logic [`MP_RX_AW-1:0] wr_ptr;
   logic [`MP_RX_AW-1:0] rd_ptr;
   mp_level_t            level;
   logic                 empty;
   logic                 full;
   flit_t                rx_mem [`MP_RX_DEPTH];
   flit_data_t           head_data;
   flit_type_t           head_type;

   assign offset    = wb_adr_i[3:2];            // Word offset within the adapter
   assign req       = stb_i & ~ack_o;
   assign send_free = ~noc_out_valid_o | noc_out_ready_i; // Drains this edge
   assign do_send   = req & wb_we_i & send_free;
   assign push      = noc_in_valid_i & noc_in_ready_o;
   assign pop       = req & ~wb_we_i & (offset == 2'd0) & ~empty;
   assign {head_type, head_data} = rx_mem[rd_ptr];

   mp_fifo_count u_rx_count (
      .clk (clk), .rst_i (rst_i), .push_i (push), .pop_i (pop),
      .wr_ptr_o (wr_ptr), .rd_ptr_o (rd_ptr), .level_o (level),
      .empty_o (empty), .full_o (full)
   );

   always_ff @(posedge clk) begin
      if (push)
         rx_mem[wr_ptr] <= noc_in_flit_i;
   end

   always_ff @(posedge clk) begin
      if (rst_i) begin
         ack_o           <= 1'b0;
         noc_out_valid_o <= 1'b0;
      end else begin
         ack_o <= req & (~wb_we_i | send_free); // Writes wait for a free send reg
         if (do_send)
            noc_out_valid_o <= 1'b1;
         else if (noc_out_ready_i)
            noc_out_valid_o <= 1'b0;
      end
   end

   // Send register payload, stable while valid
   always_ff @(posedge clk) begin
      if (do_send)
         noc_out_flit_o <= {flit_type_t'(offset), flit_data_t'(wb_dat_i)};
   end

   always_ff @(posedge clk) begin
      if (req && !wb_we_i) begin
         case (offset)
            2'd0:    dat_o <= empty ? '0 : wb_dat_t'(head_data);
            2'd1:    dat_o <= wb_dat_t'(level);
            2'd2:    dat_o <= empty ? '0 : wb_dat_t'(head_type);
            default: dat_o <= '0;
         endcase
      end
   end

   assign noc_in_ready_o = ~full;
   assign irq_o          = ~empty;              // Registered flag, one cycle after push

endmodule

`default_nettype wire

//--- verilog/compute_tile_dm.sv
// ********************
// Compute tile, one external bus master, three slaves
// Master must hold its request until ack or err
// ********************
`timescale 1ns/1ns
`default_nettype none

module compute_tile_dm import tile_bus_pkg::*, tile_noc_pkg::*; (
   input  logic    clk,
   input  logic    rst_i,
   input  wb_adr_t wb_adr_i,
   input  wb_dat_t wb_dat_i,
   input  wb_sel_t wb_sel_i,
   input  logic    wb_we_i,
   input  logic    wb_cyc_i,
   input  logic    wb_stb_i,
   input  flit_t   noc_in_flit_i,
   input  logic    noc_in_valid_i,
   input  logic    noc_out_ready_i,
   output wb_dat_t wb_dat_o,
   output logic    wb_ack_o,
   output logic    wb_err_o,
   output logic    noc_in_ready_o,
   output flit_t   noc_out_flit_o,
   output logic    noc_out_valid_o,
   output logic    irq_o
);

   logic    mem_stb;                            // Per-slave strobes from controller
   logic    na_stb;
   logic    rom_stb;
   logic    mem_ack;
   logic    na_ack;
   logic    rom_ack;
   wb_dat_t mem_dat;
   wb_dat_t na_dat;
   wb_dat_t rom_dat;

   wb_bus_ctrl u_bus (
      .clk       (clk),
      .rst_i     (rst_i),
      .wb_adr_i  (wb_adr_i),
      .wb_cyc_i  (wb_cyc_i),
      .wb_stb_i  (wb_stb_i),
      .mem_ack_i (mem_ack),
      .mem_dat_i (mem_dat),
      .na_ack_i  (na_ack),
      .na_dat_i  (na_dat),
      .rom_ack_i (rom_ack),
      .rom_dat_i (rom_dat),
      .mem_stb_o (mem_stb),
      .na_stb_o  (na_stb),
      .rom_stb_o (rom_stb),
      .wb_dat_o  (wb_dat_o),
      .wb_ack_o  (wb_ack_o),
      .wb_err_o  (wb_err_o)
   );

   wb_sram_sp u_ram (
      .clk (clk), .wb_adr_i (wb_adr_i), .wb_dat_i (wb_dat_i), .wb_sel_i (wb_sel_i),
      .wb_we_i (wb_we_i), .stb_i (mem_stb), .ack_o (mem_ack), .dat_o (mem_dat)
   );

   bootrom u_bootrom (
      .clk (clk), .rst_i (rst_i), .wb_adr_i (wb_adr_i), .stb_i (rom_stb),
      .ack_o (rom_ack), .dat_o (rom_dat)
   );

   mp_simple_na u_na (
      .clk             (clk),
      .rst_i           (rst_i),
      .wb_adr_i        (wb_adr_i),
      .wb_dat_i        (wb_dat_i),
      .wb_we_i         (wb_we_i),
      .stb_i           (na_stb),
      .noc_in_flit_i   (noc_in_flit_i),
      .noc_in_valid_i  (noc_in_valid_i),
      .noc_out_ready_i (noc_out_ready_i),
      .ack_o           (na_ack),
      .dat_o           (na_dat),
      .noc_in_ready_o  (noc_in_ready_o),
      .noc_out_flit_o  (noc_out_flit_o),
      .noc_out_valid_o (noc_out_valid_o),
      .irq_o           (irq_o)
   );

endmodule

`default_nettype wire

//--- verif/tb_compute_tile_dm.sv
// ********************
// Testbench for the compute tile with one bus master model
// SRAM reads only touch words first written with all byte selects
// ********************
`timescale 1ns/1ns
`default_nettype none

`include "tile_macros.svh"

module tb_compute_tile_dm import tile_bus_pkg::*, tile_noc_pkg::*; ();

   localparam int wait_max   = 200;             // Cycles allowed per wait loop
   localparam int sram_words = 16;              // Words used by the SRAM test

   logic    clk;
   logic    rst_i;
   wb_adr_t wb_adr_i;
   wb_dat_t wb_dat_i;
   wb_sel_t wb_sel_i;
   logic    wb_we_i;
   logic    wb_cyc_i;
   logic    wb_stb_i;
   flit_t   noc_in_flit_i;
   logic    noc_in_valid_i;
   logic    noc_out_ready_i;
   wb_dat_t wb_dat_o;
   logic    wb_ack_o;
   logic    wb_err_o;
   logic    noc_in_ready_o;
   flit_t   noc_out_flit_o;
   logic    noc_out_valid_o;
   logic    irq_o;

   int      assert_errors;
   int      data_errors;
   int      seed_val;
   flit_t   out_q [$];                          // Flits taken from noc_out
   flit_t   sent_q [$];                         // Flits written through the adapter
   flit_t   in_q [$];                           // Flits pushed into noc_in
   wb_dat_t rom_exp [`ROM_WORDS];
   wb_dat_t ram_model [sram_words];
   int      ram_idx [sram_words];

   initial clk = 1'b0;
   always #5 clk = ~clk;                        // 10 ns period

   compute_tile_dm dut0 (
      .clk (clk), .rst_i (rst_i), .wb_adr_i (wb_adr_i), .wb_dat_i (wb_dat_i),
      .wb_sel_i (wb_sel_i), .wb_we_i (wb_we_i), .wb_cyc_i (wb_cyc_i), .wb_stb_i (wb_stb_i),
      .noc_in_flit_i (noc_in_flit_i), .noc_in_valid_i (noc_in_valid_i),
      .noc_out_ready_i (noc_out_ready_i), .wb_dat_o (wb_dat_o), .wb_ack_o (wb_ack_o),
      .wb_err_o (wb_err_o), .noc_in_ready_o (noc_in_ready_o),
      .noc_out_flit_o (noc_out_flit_o), .noc_out_valid_o (noc_out_valid_o), .irq_o (irq_o)
   );

   // NoC sink with ready high about one cycle in four, so sends back up
   always @(posedge clk) begin
      if (rst_i)
         noc_out_ready_i <= 1'b0;
      else
         noc_out_ready_i <= ($urandom % 4) == 0;
   end

   always @(negedge clk) begin
      if (!rst_i && noc_out_valid_o && noc_out_ready_i)
         out_q.push_back(noc_out_flit_o);       // Transfers on the coming edge
   end

   task automatic report_protocol(input string msg);
      assert_errors++;
      $display("error at %0t: %s", $time, msg);
   endtask

   ack_pulse: assert property (@(posedge clk) disable iff (rst_i) wb_ack_o |=> !wb_ack_o)
      else report_protocol("wb_ack_o high for more than one cycle");
   err_pulse: assert property (@(posedge clk) disable iff (rst_i) wb_err_o |=> !wb_err_o)
      else report_protocol("wb_err_o high for more than one cycle");
   ack_err_excl: assert property (@(posedge clk) disable iff (rst_i) !(wb_ack_o && wb_err_o))
      else report_protocol("wb_ack_o and wb_err_o high together");
   out_hold: assert property (@(posedge clk) disable iff (rst_i)
         (noc_out_valid_o && !noc_out_ready_i) |=> (noc_out_valid_o && $stable(noc_out_flit_o)))
      else report_protocol("noc_out flit dropped or changed while stalled");
   irq_level: assert property (@(posedge clk) disable iff (rst_i)
         (wb_ack_o && !wb_we_i && wb_adr_i[`ADR_W-1 -: 4] == `NA_REGION && wb_adr_i[3:2] == 2'd1)
         |-> (irq_o == (wb_dat_o != '0)))
      else report_protocol("irq_o disagrees with the level read");

   task automatic stop_on_timeout(input string what);
      $display("timeout at %0t: no progress while waiting for %s", $time, what);
      $display("Test FAILED");
      $finish;
   endtask

   task automatic compare_word(input wb_dat_t got, input wb_dat_t exp, input string what);
      assert (got === exp) else begin
         data_errors++;
         $display("error at %0t: %s read %h, expected %h", $time, what, got, exp);
      end
   endtask

   // One bus cycle held until ack or err
   task automatic bus_access(input wb_adr_t adr, input logic we, input wb_dat_t wdat,
                             input wb_sel_t sel, output wb_dat_t rdat, output logic err);
      int   cnt;
      logic done;
      done = 1'b0;
      rdat = '0;
      err  = 1'b0;
      @(posedge clk);
      wb_adr_i <= adr;
      wb_dat_i <= wdat;
      wb_sel_i <= sel;
      wb_we_i  <= we;
      wb_cyc_i <= 1'b1;
      wb_stb_i <= 1'b1;
      for (cnt = 0; cnt < wait_max && !done; cnt++) begin
         @(negedge clk);
         if (wb_ack_o || wb_err_o) begin
            done = 1'b1;
            rdat = wb_dat_o;
            err  = wb_err_o;
         end
      end
      if (!done) begin
         stop_on_timeout("bus ack or err");
      end else begin
         @(posedge clk);                        // Drop on the edge that ends the pulse
         wb_cyc_i <= 1'b0;
         wb_stb_i <= 1'b0;
      end
   endtask

   task automatic bus_write(input wb_adr_t adr, input wb_dat_t wdat, input wb_sel_t sel);
      wb_dat_t rdat;
      logic    err;
      bus_access(adr, 1'b1, wdat, sel, rdat, err);
   endtask

   task automatic bus_read(input wb_adr_t adr, output wb_dat_t rdat);
      logic err;
      bus_access(adr, 1'b0, '0, 4'hF, rdat, err);
   endtask

   task automatic send_flit(input flit_t f);
      int   cnt;
      logic took;
      took = 1'b0;
      @(posedge clk);
      noc_in_flit_i  <= f;
      noc_in_valid_i <= 1'b1;
      for (cnt = 0; cnt < wait_max && !took; cnt++) begin
         @(negedge clk);
         took = noc_in_ready_o;                 // Accepted on the coming edge
      end
      if (!took) begin
         stop_on_timeout("noc_in_ready_o");
      end else begin
         @(posedge clk);
         noc_in_valid_i <= 1'b0;
      end
   endtask

   task automatic wait_out_flits(input int n);
      int cnt;
      cnt = 0;
      while (out_q.size() < n && cnt < wait_max) begin
         @(negedge clk);
         cnt++;
      end
      if (out_q.size() < n)
         stop_on_timeout("flits on noc_out");
   endtask

   // Random alias above the word index with bit 31 clear
   function automatic wb_adr_t sram_adr(input int idx);
      wb_adr_t a;
      a = $urandom;
      a[`ADR_W-1] = 1'b0;
      a[`MEM_AW+1:2] = idx[`MEM_AW-1:0];
      a[1:0] = 2'b00;
      return a;
   endfunction

   function automatic wb_adr_t rom_adr(input int idx);
      wb_adr_t a;
      a = $urandom;
      a[`ADR_W-1 -: 4] = `ROM_REGION;
      a[`ROM_AW+1:2] = idx[`ROM_AW-1:0];
      a[1:0] = 2'b00;
      return a;
   endfunction

   function automatic wb_adr_t na_adr(input int off);
      return {`NA_REGION, 24'h000000, off[1:0], 2'b00};
   endfunction

   initial begin
      wb_dat_t rdat;
      wb_dat_t wdat;
      wb_adr_t adr;
      wb_sel_t sel;
      logic    err;
      flit_t   f;
      int      k;
      seed_val = $urandom(32'ha1e3);
      rom_exp = '{`BOOTROM_WORD_0, `BOOTROM_WORD_1, `BOOTROM_WORD_2, `BOOTROM_WORD_3,
                  `BOOTROM_WORD_4, `BOOTROM_WORD_5, `BOOTROM_WORD_6, `BOOTROM_WORD_7};
      rst_i = 1'b1;
      wb_adr_i = '0;
      wb_dat_i = '0;
      wb_sel_i = '0;
      wb_we_i = 1'b0;
      wb_cyc_i = 1'b0;
      wb_stb_i = 1'b0;
      noc_in_flit_i = '0;
      noc_in_valid_i = 1'b0;
      noc_out_ready_i = 1'b0;
      repeat (3) @(posedge clk);
      rst_i <= 1'b0;

      // SRAM full-word fill then random byte lanes through aliases
      for (int i = 0; i < sram_words; i++) begin
         ram_idx[i] = i * 16 + int'($urandom_range(15));
         ram_model[i] = $urandom;
         bus_write(sram_adr(ram_idx[i]), ram_model[i], 4'hF);
      end
      for (int n = 0; n < 48; n++) begin
         k = $urandom_range(sram_words - 1);
         wdat = $urandom;
         sel = wb_sel_t'($urandom);
         bus_write(sram_adr(ram_idx[k]), wdat, sel);
         for (int b = 0; b < `SEL_W; b++)
            if (sel[b])
               ram_model[k][8*b +: 8] = wdat[8*b +: 8];
      end
      for (int i = 0; i < sram_words; i++) begin
         bus_read(sram_adr(ram_idx[i]), rdat);
         compare_word(rdat, ram_model[i], "sram word");
      end

      for (int i = 0; i < 2 * `ROM_WORDS; i++) begin
         bus_read(rom_adr(i), rdat);
         compare_word(rdat, rom_exp[i % `ROM_WORDS], "boot rom");
      end
      bus_write(rom_adr(3), 32'hDEADBEEF, 4'hF);
      bus_read(rom_adr(3), rdat);
      compare_word(rdat, rom_exp[3], "boot rom after write");

      for (int r = 8; r <= 13; r++) begin      // Unmapped regions
         adr = $urandom;
         adr[`ADR_W-1 -: 4] = r[3:0];
         bus_access(adr, r[0], $urandom, 4'hF, rdat, err);
         compare_word(wb_dat_t'(err), 32'd1, "error flag");
         compare_word(rdat, '0, "unmapped data");
      end

      // Adapter send in two rounds of all four flit types
      for (int n = 0; n < 8; n++) begin
         wdat = $urandom;
         sent_q.push_back({flit_type_t'(n % 4), flit_data_t'(wdat)});
         bus_write(na_adr(n % 4), wdat, 4'hF);
      end
      wait_out_flits(8);
      while (sent_q.size() > 0) begin
         f = sent_q.pop_front();
         compare_word(wb_dat_t'(out_q[0][`FLIT_W-1 -: `FLIT_TYPE_W]),
                      wb_dat_t'(f[`FLIT_W-1 -: `FLIT_TYPE_W]), "noc_out type");
         compare_word(out_q[0][`DAT_W-1:0], f[`DAT_W-1:0], "noc_out payload");
         out_q.pop_front();
      end

      // Adapter receive fills the queue then drains it
      for (int n = 0; n < `MP_RX_DEPTH; n++) begin
         f = {flit_type_t'($urandom), flit_data_t'($urandom)};
         in_q.push_back(f);
         send_flit(f);
         bus_read(na_adr(1), rdat);
         compare_word(rdat, wb_dat_t'(n + 1), "receive level");
      end
      @(negedge clk);
      compare_word(wb_dat_t'(noc_in_ready_o), '0, "noc_in_ready_o when full");
      while (in_q.size() > 0) begin
         f = in_q.pop_front();
         bus_read(na_adr(2), rdat);
         compare_word(rdat, wb_dat_t'(f[`FLIT_W-1 -: `FLIT_TYPE_W]), "head type");
         bus_read(na_adr(0), rdat);
         compare_word(rdat, f[`DAT_W-1:0], "head payload");
      end
      bus_read(na_adr(1), rdat);
      compare_word(rdat, '0, "level after drain");
      bus_read(na_adr(0), rdat);
      compare_word(rdat, '0, "read of empty queue");
      @(negedge clk);
      compare_word(wb_dat_t'(irq_o), '0, "irq_o after drain");

      repeat (2) @(posedge clk);
      $display("Checks done: %0d assertion errors, %0d data errors", assert_errors, data_errors);
      if (assert_errors + data_errors == 0)
         $display("Test OK");
      else
         $display("Test FAILED");
      $finish;
   end

endmodule

`default_nettype wire

//--- compute_tile_dm.f
+incdir+verilog
verilog/tile_bus_pkg.sv
verilog/tile_noc_pkg.sv
verilog/wb_bus_ctrl.sv
verilog/wb_sram_sp.sv
verilog/bootrom.sv
verilog/mp_fifo_count.sv
verilog/mp_simple_na.sv
verilog/compute_tile_dm.sv
verif/tb_compute_tile_dm.sv

//--- run_sim.sh
#!/bin/sh
# Builds the compute tile testbench with Verilator and runs it.
# The exit status is nonzero when the build, the run or a check fails.
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal -f compute_tile_dm.f \
   --top-module tb_compute_tile_dm -Mdir obj_dir -o sim > build.log 2>&1 \
   && ./obj_dir/sim > sim.log 2>&1 \
   || { cat build.log sim.log 2>/dev/null; echo "build or run of the simulation failed"; exit 1; }
cat sim.log
grep -q "Test FAILED" sim.log && { echo "simulation reported failure"; exit 1; }
echo "simulation passed"
exit 0
